// File: source/smu_ctl_pkg.sv
////////////////////////////////////////////////////////////////////////////
// shared widths, register map and defaults for the smu control FPGA
// import into any module that decodes frames or updates registers
////////////////////////////////////////////////////////////////////////////
package smu_ctl_pkg;

  // spi frame layout, address in the high byte, value in the low byte
  localparam int FRAME_BITS = 16;
  localparam int ADDR_BITS  = 8;
  localparam int VAL_BITS   = 8;

  // each control register is one nibble
  localparam int CTL_BITS   = 4;
  localparam int NUM_PERIPH = 4;
  localparam int NUM_REGS   = 8;

  localparam logic [ADDR_BITS-1:0] ADDR_SOFT_RESET = 8'd11;

  // register index into the bank
  localparam int IDX_LED         = 0;
  localparam int IDX_MUX         = 1;
  localparam int IDX_DAC_CTL     = 2;
  localparam int IDX_RAILS       = 3;
  localparam int IDX_DAC_REF_MUX = 4;
  localparam int IDX_ADC_CTL     = 5;
  localparam int IDX_CLAMP1      = 6;
  localparam int IDX_RAILS_OE    = 7;

  // spi address of each register, by index
  localparam logic [ADDR_BITS-1:0] REG_ADDR [NUM_REGS] = '{
    8'd7, 8'd8, 8'd9, 8'd10, 8'd12, 8'd14, 8'd15, 8'd24
  };

  // power-on values
  // dac_ref_mux and clamp1 switches are active low, so all off
  // rails_oe bit 0 active low, keeps rails disabled until asked
  localparam logic [CTL_BITS-1:0] REG_DEFAULT [NUM_REGS] = '{
    4'b0000, 4'b0000, 4'b0000, 4'b0000, 4'b1111, 4'b0000, 4'b1111, 4'b0001
  };

  // value byte low nibble sets, high nibble clears
  // a bit both set and cleared toggles instead
  function automatic logic [CTL_BITS-1:0] ctl_update(
    input logic [CTL_BITS-1:0] old,
    input logic [VAL_BITS-1:0] val
  );
    logic [CTL_BITS-1:0] set_mask;
    logic [CTL_BITS-1:0] clr_mask;
    logic [CTL_BITS-1:0] both;
    set_mask = val[CTL_BITS-1:0];
    clr_mask = val[2*CTL_BITS-1:CTL_BITS];
    both     = set_mask & clr_mask;
    if (both != '0)
      return old ^ both;
    return (old | set_mask) & ~clr_mask;
  endfunction

endpackage

// File: source/spi_input_sync.sv
////////////////////////////////////////////////////////////////////////////
// brings the slow spi pins into the clk domain through two flops
// and flags sclk rising and cs_n rising as single-cycle pulses
////////////////////////////////////////////////////////////////////////////
module spi_input_sync (
  input  logic clk,
  input  logic rst,
  input  logic sclk,
  input  logic cs_n,
  input  logic special_n,
  input  logic mosi,
  output logic mosi_s,
  output logic cs_n_s,
  output logic special_n_s,
  output logic sclk_rise,
  output logic cs_rise
);

  // pin order special_n, cs_n, sclk, mosi
  // idle selects high, clock and data low
  localparam logic [3:0] IDLE = 4'b1100;

  logic [3:0] meta;
  logic [3:0] sync;
  logic       sclk_prev;
  logic       cs_n_prev;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      meta      <= IDLE;
      sync      <= IDLE;
      sclk_prev <= 1'b0;
      cs_n_prev <= 1'b1;
    end
    else
    begin
      meta      <= {special_n, cs_n, sclk, mosi};
      sync      <= meta;
      // one more stage for edge compare
      sclk_prev <= sync[1];
      cs_n_prev <= sync[2];
    end
  end

  assign special_n_s = sync[3];
  assign cs_n_s      = sync[2];
  assign mosi_s      = sync[0];

  // edges, valid the same cycle the synced level changes
  assign sclk_rise = sync[1] & ~sclk_prev;
  assign cs_rise   = sync[2] & ~cs_n_prev;

endmodule

// File: source/spi_frame_receiver.sv
////////////////////////////////////////////////////////////////////////////
// collects one special spi frame, msb first, from the synced pins
// and strobes address and value out when cs_n closes on 16 bits
////////////////////////////////////////////////////////////////////////////
module spi_frame_receiver (
  input  logic                             clk,
  input  logic                             rst,
  input  logic                             mosi_s,
  input  logic                             cs_n_s,
  input  logic                             special_n_s,
  input  logic                             sclk_rise,
  input  logic                             cs_rise,
  output logic                             wr_strobe,
  output logic [smu_ctl_pkg::ADDR_BITS-1:0] wr_addr,
  output logic [smu_ctl_pkg::VAL_BITS-1:0]  wr_val
);

  import smu_ctl_pkg::*;

  // one spare bit so an overlong frame never looks like 16
  localparam int CNT_BITS = $clog2(FRAME_BITS) + 1;

  logic [FRAME_BITS-1:0] shift;
  logic [CNT_BITS-1:0]   bit_cnt;
  logic                  active;

  assign active = ~cs_n_s & ~special_n_s;

  // shift register, first bit ends up as msb
  always_ff @(posedge clk)
  begin
    if (active && sclk_rise)
      shift <= {shift[FRAME_BITS-2:0], mosi_s};
  end

  // bit counter, saturates, cleared between frames
  always_ff @(posedge clk)
  begin
    if (rst || cs_n_s)
      bit_cnt <= '0;
    else if (active && sclk_rise && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // counter still holds the frame length on the cs_rise cycle
  always_ff @(posedge clk)
  begin
    if (rst)
      wr_strobe <= 1'b0;
    else
      wr_strobe <= cs_rise && !special_n_s && (bit_cnt == CNT_BITS'(FRAME_BITS));
  end

  // shift is frozen once cs_n is high, so these hold with the strobe
  assign wr_addr = shift[FRAME_BITS-1:VAL_BITS];
  assign wr_val  = shift[VAL_BITS-1:0];

endmodule

// File: source/control_register.sv
////////////////////////////////////////////////////////////////////////////
// one nibble control register, set/clear/toggle on write
// reset or a soft-reset load puts it back to RESET_VALUE
////////////////////////////////////////////////////////////////////////////
module control_register #(
  parameter logic [smu_ctl_pkg::CTL_BITS-1:0] RESET_VALUE = '0
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              load_default,
  input  logic                              write,
  input  logic [smu_ctl_pkg::VAL_BITS-1:0]  wr_val,
  output logic [smu_ctl_pkg::CTL_BITS-1:0] q
);

  import smu_ctl_pkg::*;

  always_ff @(posedge clk)
  begin
    // soft reset takes priority over a write
    if (rst || load_default)
      q <= RESET_VALUE;
    else if (write)
      q <= ctl_update(q, wr_val);
  end

endmodule

// File: source/register_file.sv
////////////////////////////////////////////////////////////////////////////
// address decode for the control register bank
// one register per table entry, soft-reset address reloads all
////////////////////////////////////////////////////////////////////////////
module register_file (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  logic                                                      wr_strobe,
  input  logic [smu_ctl_pkg::ADDR_BITS-1:0]                         wr_addr,
  input  logic [smu_ctl_pkg::VAL_BITS-1:0]                          wr_val,
  output logic [smu_ctl_pkg::NUM_REGS-1:0][smu_ctl_pkg::CTL_BITS-1:0] regs
);

  import smu_ctl_pkg::*;

  logic                load_default;
  logic [NUM_REGS-1:0] reg_write;

  /////////////////////////////////////////////////////////////////////////
  // decode

  // soft reset hits every register at once
  assign load_default = wr_strobe && (wr_addr == ADDR_SOFT_RESET);

  // unknown addresses match nothing and drop out here
  always_comb
  begin
    for (int i = 0; i < NUM_REGS; i++)
      reg_write[i] = wr_strobe && (wr_addr == REG_ADDR[i]);
  end

  /////////////////////////////////////////////////////////////////////////
  // bank

  for (genvar i = 0; i < NUM_REGS; i++)
  begin : g_reg
    control_register #(
      .RESET_VALUE (REG_DEFAULT[i])
    ) i_reg (
      .clk          (clk),
      .rst          (rst),
      .load_default (load_default),
      .write        (reg_write[i]),
      .wr_val       (wr_val),
      .q            (regs[i])
    );
  end

endmodule

// File: source/spi_peripheral_router.sv
////////////////////////////////////////////////////////////////////////////
// routes the shared chip select and miso to the downstream peripherals
// purely combinational, follows the pins with no clk delay
////////////////////////////////////////////////////////////////////////////
module spi_peripheral_router (
  input  logic                               cs_n,
  input  logic                               special_n,
  input  logic [smu_ctl_pkg::NUM_PERIPH-1:0] mux_sel,
  input  logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_miso,
  output logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_cs_n,
  output logic                               miso
);

  // peripherals stay deselected during a special frame
  // so register writes never leak into them
  always_comb
  begin
    if (!special_n || cs_n)
      periph_cs_n = '1;
    else
      periph_cs_n = ~mux_sel;
  end

  // wired-or of the selected miso lines
  // own fpga miso has nothing to return, held low
  assign miso = special_n ? |(mux_sel & periph_miso) : 1'b0;

endmodule

// File: source/smu_ctl_top.sv
////////////////////////////////////////////////////////////////////////////
// smu control FPGA top level
// spi register bank plus chip-select routing to adc03, dac, flash, adc02
////////////////////////////////////////////////////////////////////////////
module smu_ctl_top (
  input  logic                               clk,
  input  logic                               rst,
  input  logic                               sclk,
  input  logic                               cs_n,
  input  logic                               special_n,
  input  logic                               mosi,
  input  logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_miso,
  output logic                               miso,
  output logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_cs_n,
  output logic [smu_ctl_pkg::CTL_BITS-1:0]   led,
  output logic [smu_ctl_pkg::CTL_BITS-1:0]   dac_ctl,
  output logic [smu_ctl_pkg::CTL_BITS-1:0]   rails,
  output logic [smu_ctl_pkg::CTL_BITS-1:0]   dac_ref_mux,
  output logic [smu_ctl_pkg::CTL_BITS-1:0]   adc_ctl,
  output logic [smu_ctl_pkg::CTL_BITS-1:0]   clamp1,
  output logic [smu_ctl_pkg::CTL_BITS-1:0]   rails_oe
);

  import smu_ctl_pkg::*;

  logic                               mosi_s;
  logic                               cs_n_s;
  logic                               special_n_s;
  logic                               sclk_rise;
  logic                               cs_rise;
  logic                               wr_strobe;
  logic [ADDR_BITS-1:0]               wr_addr;
  logic [VAL_BITS-1:0]                wr_val;
  logic [NUM_REGS-1:0][CTL_BITS-1:0]  regs;
  logic [NUM_PERIPH-1:0]              mux_sel;

  /////////////////////////////////////////////////////////////////////////
  // spi receive path, 2 sync + 1 strobe + 1 update cycles

  spi_input_sync i_sync (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .mosi_s      (mosi_s),
    .cs_n_s      (cs_n_s),
    .special_n_s (special_n_s),
    .sclk_rise   (sclk_rise),
    .cs_rise     (cs_rise)
  );

  spi_frame_receiver i_rx (
    .clk         (clk),
    .rst         (rst),
    .mosi_s      (mosi_s),
    .cs_n_s      (cs_n_s),
    .special_n_s (special_n_s),
    .sclk_rise   (sclk_rise),
    .cs_rise     (cs_rise),
    .wr_strobe   (wr_strobe),
    .wr_addr     (wr_addr),
    .wr_val      (wr_val)
  );

  register_file i_regs (
    .clk       (clk),
    .rst       (rst),
    .wr_strobe (wr_strobe),
    .wr_addr   (wr_addr),
    .wr_val    (wr_val),
    .regs      (regs)
  );

  /////////////////////////////////////////////////////////////////////////
  // routing, straight from the raw pins

  // one mux bit per peripheral
  assign mux_sel = regs[IDX_MUX][NUM_PERIPH-1:0];

  spi_peripheral_router i_router (
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mux_sel     (mux_sel),
    .periph_miso (periph_miso),
    .periph_cs_n (periph_cs_n),
    .miso        (miso)
  );

  // board control nibbles
  assign led         = regs[IDX_LED];
  assign dac_ctl     = regs[IDX_DAC_CTL];
  assign rails       = regs[IDX_RAILS];
  assign dac_ref_mux = regs[IDX_DAC_REF_MUX];
  assign adc_ctl     = regs[IDX_ADC_CTL];
  assign clamp1      = regs[IDX_CLAMP1];
  assign rails_oe    = regs[IDX_RAILS_OE];

endmodule

// File: sim/smu_ctl_asserts.sv
////////////////////////////////////////////////////////////////////////////
// concurrent checks on chip-select fan-out and the write strobe
// bound into every instance of the control top level
////////////////////////////////////////////////////////////////////////////
module smu_ctl_asserts (
  input logic                               clk,
  input logic                               rst,
  input logic                               cs_n,
  input logic                               special_n,
  input logic [smu_ctl_pkg::NUM_PERIPH-1:0] periph_cs_n,
  input logic                               wr_strobe
);

  // special frames belong to the fpga alone
  a_special_deselects: assert property (
    @(posedge clk) disable iff (rst) !special_n |-> (periph_cs_n == '1)
  ) else $error("peripheral selected during a special frame");

  // idle bus, nothing selected
  a_idle_deselects: assert property (
    @(posedge clk) disable iff (rst) cs_n |-> (periph_cs_n == '1)
  ) else $error("peripheral selected while cs_n is high");

  a_strobe_single: assert property (
    @(posedge clk) disable iff (rst) wr_strobe |=> !wr_strobe
  ) else $error("write strobe held for more than one cycle");

endmodule

bind smu_ctl_top smu_ctl_asserts i_asserts (
  .clk         (clk),
  .rst         (rst),
  .cs_n        (cs_n),
  .special_n   (special_n),
  .periph_cs_n (periph_cs_n),
  .wr_strobe   (wr_strobe)
);

// File: sim/smu_ctl_tb.sv
////////////////////////////////////////////////////////////////////////////
// testbench for the smu control top level
// random spi frames from an lcg, checked against a register model
////////////////////////////////////////////////////////////////////////////
module smu_ctl_tb;

  import smu_ctl_pkg::*;

  localparam int HALF_SCLK  = 4;
  localparam int N_RAND     = 40;
  // frames sent over the whole run
  // random, pre-reset writes, soft reset, ignored, mux
  localparam int NUM_FRAMES = N_RAND + N_RAND / 2 + 1 + 4 * 3 + 8;

  logic                  clk;
  logic                  rst;
  logic                  sclk;
  logic                  cs_n;
  logic                  special_n;
  logic                  mosi;
  logic [NUM_PERIPH-1:0] periph_miso;
  logic [NUM_PERIPH-1:0] periph_cs_n;
  logic                  miso;
  logic [CTL_BITS-1:0]   led;
  logic [CTL_BITS-1:0]   dac_ctl;
  logic [CTL_BITS-1:0]   rails;
  logic [CTL_BITS-1:0]   dac_ref_mux;
  logic [CTL_BITS-1:0]   adc_ctl;
  logic [CTL_BITS-1:0]   clamp1;
  logic [CTL_BITS-1:0]   rails_oe;

  // expected register contents, by index
  logic [CTL_BITS-1:0] model [NUM_REGS];
  logic [31:0]         seed = 32'h4e6180ad;
  int                  checks = 0;
  int                  errors = 0;
  int                  test_start = 0;

  smu_ctl_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .sclk        (sclk),
    .cs_n        (cs_n),
    .special_n   (special_n),
    .mosi        (mosi),
    .periph_miso (periph_miso),
    .miso        (miso),
    .periph_cs_n (periph_cs_n),
    .led         (led),
    .dac_ctl     (dac_ctl),
    .rails       (rails),
    .dac_ref_mux (dac_ref_mux),
    .adc_ctl     (adc_ctl),
    .clamp1      (clamp1),
    .rails_oe    (rails_oe)
  );

  initial
  begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers

  // low lcg bits repeat after a few steps, hand out the upper half
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return {16'h0000, seed[31:16]};
  endfunction

  // low nibble sets, high nibble clears, overlap toggles
  function automatic logic [CTL_BITS-1:0] expected_update(
    input logic [CTL_BITS-1:0] old,
    input logic [VAL_BITS-1:0] val
  );
    logic [CTL_BITS-1:0] set_bits;
    logic [CTL_BITS-1:0] clr_bits;
    set_bits = val[3:0];
    clr_bits = val[7:4];
    if ((set_bits & clr_bits) != 4'b0000)
      return old ^ (set_bits & clr_bits);
    return (old | set_bits) & ~clr_bits;
  endfunction

  function automatic bit is_decoded(input logic [ADDR_BITS-1:0] addr);
    for (int i = 0; i < NUM_REGS; i++)
      if (addr == REG_ADDR[i])
        return 1'b1;
    return addr == ADDR_SOFT_RESET;
  endfunction

  // mux has no pin of its own, handled apart
  function automatic logic [CTL_BITS-1:0] reg_output(input int idx);
    case (idx)
      IDX_LED:         return led;
      IDX_DAC_CTL:     return dac_ctl;
      IDX_RAILS:       return rails;
      IDX_DAC_REF_MUX: return dac_ref_mux;
      IDX_ADC_CTL:     return adc_ctl;
      IDX_CLAMP1:      return clamp1;
      IDX_RAILS_OE:    return rails_oe;
      default:         return 4'b0000;
    endcase
  endfunction

  // wait n rising edges, then step past them
  task automatic tick(input int n);
    repeat (n) @(posedge clk);
    #5;
  endtask

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("Mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
    end
  endtask

  // msb first, nbits below 16 cuts the frame short
  task automatic send_frame(input logic [FRAME_BITS-1:0] data, input int nbits,
                            input logic spec_n);
    special_n = spec_n;
    cs_n      = 1'b0;
    tick(HALF_SCLK);
    for (int i = 0; i < nbits; i++)
    begin
      mosi = data[FRAME_BITS-1-i];
      sclk = 1'b0;
      tick(HALF_SCLK);
      sclk = 1'b1;
      tick(HALF_SCLK);
    end
    sclk = 1'b0;
    tick(HALF_SCLK);
    cs_n = 1'b1;
    // special_n held low past the synced cs rise
    tick(8);
    special_n = 1'b1;
    mosi      = 1'b0;
  endtask

  task automatic write_reg(input int idx, input logic [VAL_BITS-1:0] val);
    send_frame({REG_ADDR[idx], val}, FRAME_BITS, 1'b0);
    model[idx] = expected_update(model[idx], val);
  endtask

  task automatic check_regs(input string tag);
    logic [NUM_PERIPH-1:0] exp_cs;
    for (int i = 0; i < NUM_REGS; i++)
      if (i != IDX_MUX)
        check(32'(reg_output(i)), 32'(model[i]), $sformatf("%s reg %0d", tag, i));
    // mux seen through the chip-select fan-out
    exp_cs    = ~model[IDX_MUX];
    special_n = 1'b1;
    cs_n      = 1'b0;
    #1;
    check(32'(periph_cs_n), 32'(exp_cs), $sformatf("%s mux", tag));
    cs_n = 1'b1;
  endtask

  task automatic end_test(input string name);
    $display("test %s done, %0d errors", name, errors - test_start);
    test_start = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // watchdog

  initial
  begin
    repeat (NUM_FRAMES * 20 * 8 + 1000) @(posedge clk);
    $display("timeout: run went past the cycle limit");
    $display("*** FAILED ***");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // tests

  initial
  begin
    logic [ADDR_BITS-1:0]  addr;
    logic [VAL_BITS-1:0]   val;
    logic [NUM_PERIPH-1:0] exp_cs;
    logic                  exp_miso;
    int                    idx;
    rst         = 1'b1;
    sclk        = 1'b0;
    cs_n        = 1'b1;
    special_n   = 1'b1;
    mosi        = 1'b0;
    periph_miso = '0;
    for (int i = 0; i < NUM_REGS; i++)
      model[i] = REG_DEFAULT[i];
    tick(10);
    rst = 1'b0;
    tick(2);
    check_regs("reset");
    end_test("reset defaults");

    for (int n = 0; n < N_RAND; n++)
    begin
      idx = int'(lcg_next() % 32'(NUM_REGS));
      write_reg(idx, 8'(lcg_next()));
      check_regs("random write");
    end
    end_test("random writes");

    for (int n = 0; n < N_RAND / 2; n++)
    begin
      idx = int'(lcg_next() % 32'(NUM_REGS));
      write_reg(idx, 8'(lcg_next()));
    end
    send_frame({ADDR_SOFT_RESET, 8'(lcg_next())}, FRAME_BITS, 1'b0);
    for (int i = 0; i < NUM_REGS; i++)
      model[i] = REG_DEFAULT[i];
    check_regs("soft reset");
    end_test("soft reset");

    // none of these may touch a register
    for (int n = 0; n < 4; n++)
    begin
      do
        addr = 8'(lcg_next());
      while (is_decoded(addr));
      send_frame({addr, 8'(lcg_next())}, FRAME_BITS, 1'b0);
      check_regs("unknown address");
      idx = int'(lcg_next() % 32'(NUM_REGS));
      send_frame({REG_ADDR[idx], 8'(lcg_next())}, FRAME_BITS - 1, 1'b0);
      check_regs("short frame");
      idx = int'(lcg_next() % 32'(NUM_REGS));
      send_frame({REG_ADDR[idx], 8'(lcg_next())}, FRAME_BITS, 1'b1);
      check_regs("special_n high");
    end
    end_test("ignored frames");

    for (int n = 0; n < 8; n++)
    begin
      val = 8'(lcg_next());
      write_reg(IDX_MUX, val);
      periph_miso = 4'(lcg_next());
      exp_cs      = ~model[IDX_MUX];
      exp_miso    = |(model[IDX_MUX] & periph_miso);
      cs_n        = 1'b0;
      #1;
      check(32'(periph_cs_n), 32'(exp_cs), "routed chip select");
      check(32'(miso), 32'(exp_miso), "routed miso");
      // special frame, peripherals off and miso quiet
      special_n = 1'b0;
      #1;
      check(32'(periph_cs_n), 32'hf, "chip select in special frame");
      check(32'(miso), 32'h0, "miso in special frame");
      cs_n      = 1'b1;
      special_n = 1'b1;
      tick(1);
    end
    end_test("peripheral routing");

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

// File: verilog.f
source/smu_ctl_pkg.sv
source/spi_input_sync.sv
source/spi_frame_receiver.sv
source/control_register.sv
source/register_file.sv
source/spi_peripheral_router.sv
source/smu_ctl_top.sv
sim/smu_ctl_asserts.sv
sim/smu_ctl_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = smu_ctl_tb
FILELIST  = verilog.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then echo "simulation did not finish"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
